/* invctl_pkg.sv */
package invctl_pkg;

   // ----------------------------------------------------------------------
   // widths
   // ----------------------------------------------------------------------

   // return packet from the crossbar
   localparam int cpx_width   = 128;

   // icache index runs from bit 11 down to bit 5
   localparam int ic_idx_hi   = 11;
   localparam int ic_idx_sz   = 7;

   localparam int num_threads = 4;
   localparam int num_ways    = 4;
   localparam int way_w       = 2;

   // valid array is split into four 32B quadrants
   // quadrant = {index bit 6, index bit 5}
   localparam int num_quads   = 4;

   // ----------------------------------------------------------------------
   // packet header fields
   // ----------------------------------------------------------------------

   localparam int cpx_vld        = 127;
   // request type
   localparam int cpx_req_hi     = 126;
   localparam int cpx_req_lo     = 123;
   // load return carries the hit way of the icache copy
   localparam int cpx_wyvld      = 122;
   localparam int cpx_wy_hi      = 121;
   localparam int cpx_wy_lo      = 120;
   // thread of the request
   localparam int cpx_thr_hi     = 119;
   localparam int cpx_thr_lo     = 118;
   // invalidate all ways of the line
   localparam int cpx_iinv       = 117;
   // picks the 32B half for invalidate-all
   localparam int cpx_invpa5     = 116;
   // invalidate index, address bits 11 to 6
   localparam int cpx_inv_idx_hi = 115;
   localparam int cpx_inv_idx_lo = 110;

   // ----------------------------------------------------------------------
   // per-core invalidate vectors
   // ----------------------------------------------------------------------

   // word 0 and word 1 vectors
   localparam int inv_w0_base     = 0;
   localparam int inv_w1_base     = 56;
   // each pair of cores owns 8 bits
   localparam int inv_core_stride = 8;
   localparam int inv_num_pairs   = 4;
   // odd core sits in the upper nibble
   localparam int inv_odd_ofs     = 4;
   // inside one core's nibble
   // bit 0 unused, bit 1 valid, bits 3:2 way
   localparam int inv_vld_ofs     = 1;
   localparam int inv_way_ofs     = 2;

   // ----------------------------------------------------------------------
   // request types
   // ----------------------------------------------------------------------

   typedef enum logic [3:0] {
      req_load    = 4'b0000,
      req_ifill   = 4'b0001,
      req_evict   = 4'b0011,
      req_store   = 4'b0100,
      req_strmack = 4'b0110
   } cpx_req_e;

endpackage

/* cpx_inv_decode.sv */
`timescale 1ns/10ps

module cpx_inv_decode import invctl_pkg::*; #(
   parameter int unsigned core_id = 0
) (
   input  logic [cpx_width-1:0] cpx_pkt,
   output logic                 is_ld,
   output logic                 is_ifill,
   output logic                 is_inv_pkt,
   output logic                 ld_inv,
   output logic                 inv_all,
   output logic [way_w-1:0]     ld_way,
   output logic [1:0]           pkt_thr,
   output logic                 inv_pa5,
   output logic [ic_idx_hi:6]   inv_addr,
   output logic                 word0_inv,
   output logic                 word1_inv,
   output logic [way_w-1:0]     word0_way,
   output logic [way_w-1:0]     word1_way
);

   cpx_req_e   req_type;
   logic       pkt_vld;
   logic       is_st;
   logic       is_strm;
   logic       is_ev;
   logic [2:0] cpu_id;
   logic [1:0] core_pair;
   logic       core_odd;

   // pull {valid, way} for this core out of one invalidate vector
   function automatic logic [way_w:0] core_slot(
      input logic [cpx_width-1:0] pkt,
      input int                   base,
      input logic [1:0]           pair,
      input logic                 odd
   );
      logic [way_w:0] even_slot;
      logic [way_w:0] odd_slot;
      int             pos;
      even_slot = '0;
      odd_slot  = '0;
      // 4:1 over the core pairs
      for (int p = 0; p < inv_num_pairs; p++) begin
         pos = base + p * inv_core_stride;
         if (pair == 2'(p)) begin
            even_slot = {pkt[pos + inv_vld_ofs], pkt[pos + inv_way_ofs +: way_w]};
            odd_slot  = {pkt[pos + inv_odd_ofs + inv_vld_ofs],
                         pkt[pos + inv_odd_ofs + inv_way_ofs +: way_w]};
         end
      end
      // then 2:1 between even and odd core of the pair
      return odd ? odd_slot : even_slot;
   endfunction

   // ----------------------------------------------------------------------
   // packet type
   // ----------------------------------------------------------------------

   assign pkt_vld  = cpx_pkt[cpx_vld];
   assign req_type = cpx_req_e'(cpx_pkt[cpx_req_hi:cpx_req_lo]);

   assign is_ld    = pkt_vld & (req_type == req_load);
   assign is_ifill = pkt_vld & (req_type == req_ifill);
   assign is_st    = pkt_vld & (req_type == req_store);
   assign is_strm  = pkt_vld & (req_type == req_strmack);
   assign is_ev    = pkt_vld & (req_type == req_evict);

   // store acks, stream acks and evicts all carry invalidate vectors
   assign is_inv_pkt = is_st | is_strm | is_ev;

   // invalidate-all only for store and evict
   // ifq_adv qualification happens downstream
   assign inv_all = (is_st | is_ev) & cpx_pkt[cpx_iinv];

   // load that hit a line also held in the icache
   assign ld_inv  = is_ld & cpx_pkt[cpx_wyvld];
   assign ld_way  = cpx_pkt[cpx_wy_hi:cpx_wy_lo];
   assign pkt_thr = cpx_pkt[cpx_thr_hi:cpx_thr_lo];

   // invalidate address
   assign inv_pa5  = cpx_pkt[cpx_invpa5];
   assign inv_addr = cpx_pkt[cpx_inv_idx_hi:cpx_inv_idx_lo];

   // ----------------------------------------------------------------------
   // this core's slice of the invalidate vectors
   // ----------------------------------------------------------------------

   // core number split into pair and even/odd
   assign cpu_id    = 3'(core_id);
   assign core_pair = cpu_id[2:1];
   assign core_odd  = cpu_id[0];

   assign {word0_inv, word0_way} = core_slot(cpx_pkt, inv_w0_base, core_pair, core_odd);
   assign {word1_inv, word1_way} = core_slot(cpx_pkt, inv_w1_base, core_pair, core_odd);

endmodule

/* ld_index_table.sv */
`timescale 1ns/10ps

module ld_index_table import invctl_pkg::*; (
   input  logic                 rclk,
   input  logic                 reset,
   input  logic                 ld_pcx_vld,
   input  logic [1:0]           ld_pcx_tid,
   input  logic [ic_idx_hi:5]   ld_icache_index,
   input  logic [1:0]           pkt_thr,
   output logic [ic_idx_hi:5]   ld_inv_index
);

   // one icache index per thread, from its outstanding load
   logic [ic_idx_hi:5]     ld_index [num_threads];
   logic [num_threads-1:0] ld_sel;

   // decoded write select of the strobed thread
   always_comb begin
      ld_sel = '0;
      if (ld_pcx_vld) begin
         ld_sel[ld_pcx_tid] = 1'b1;
      end
   end

   // capture the index when the load goes out
   always_ff @(posedge rclk) begin
      if (reset) begin
         for (int t = 0; t < num_threads; t++) begin
            ld_index[t] <= '0;
         end
      end else begin
         for (int t = 0; t < num_threads; t++) begin
            if (ld_sel[t]) begin
               ld_index[t] <= ld_icache_index;
            end
         end
      end
   end

   // read back by the thread of the returning packet
   assign ld_inv_index = ld_index[pkt_thr];

endmodule

/* icv_write_ctl.sv */
`timescale 1ns/10ps

module icv_write_ctl import invctl_pkg::*; (
   input  logic                           rclk,
   input  logic                           reset,
   input  logic                           ifq_adv,
   input  logic [way_w-1:0]               wrway,
   input  logic [ic_idx_hi:5]             fill_index,
   input  logic                           is_ld,
   input  logic                           is_ifill,
   input  logic                           is_inv_pkt,
   input  logic                           ld_inv,
   input  logic                           inv_all,
   input  logic [way_w-1:0]               ld_way,
   input  logic                           inv_pa5,
   input  logic [ic_idx_hi:6]             inv_addr,
   input  logic                           word0_inv,
   input  logic                           word1_inv,
   input  logic [way_w-1:0]               word0_way,
   input  logic [way_w-1:0]               word1_way,
   input  logic [ic_idx_hi:5]             ld_inv_index,
   output logic [num_quads*num_ways-1:0]  icv_wren,
   output logic [ic_idx_hi:5]             icv_wrindex,
   output logic [num_ways-1:0]            ict_dec_wrway,
   output logic                           invreq,
   output logic                           inv_pending
);

   logic                 pick_wr;
   logic                 inv_hit0;
   logic                 inv_hit1;
   logic                 inv_all_adv;
   logic                 invalidate_new;
   logic [way_w-1:0]     w0_way;
   logic [way_w-1:0]     w1_way;
   logic [way_w-1:0]     w0_way_q;
   logic [way_w-1:0]     w1_way_q;
   logic [num_ways-1:0]  w0_dec_way;
   logic [num_ways-1:0]  w1_dec_way;
   logic [num_quads-1:0] wd_en_new;
   logic [num_quads-1:0] wd_en;
   logic [num_quads-1:0] wd_en_q;
   logic                 inv_q;

   // 2 to 4 way decode
   function automatic logic [num_ways-1:0] dec_way(input logic [way_w-1:0] way);
      logic [num_ways-1:0] onehot;
      onehot      = '0;
      onehot[way] = 1'b1;
      return onehot;
   endfunction

   // ----------------------------------------------------------------------
   // way selection
   // ----------------------------------------------------------------------

   // tag array always gets the fill way
   assign ict_dec_wrway = dec_way(wrway);

   assign pick_wr = is_ifill & ifq_adv;

   // fill, else held way on stall, else load way, else vector way
   assign w0_way = pick_wr  ? wrway    :
                   ~ifq_adv ? w0_way_q :
                   ld_inv   ? ld_way   :
                              word0_way;
   assign w1_way = pick_wr  ? wrway    :
                   ~ifq_adv ? w1_way_q :
                   ld_inv   ? ld_way   :
                              word1_way;

   assign w0_dec_way = dec_way(w0_way);
   assign w1_dec_way = dec_way(w1_way);

   // ----------------------------------------------------------------------
   // word enables per 32B quadrant
   // ----------------------------------------------------------------------

   assign inv_hit0 = is_inv_pkt & word0_inv;
   assign inv_hit1 = is_inv_pkt & word1_inv;

   // even quadrants belong to word 0, odd ones to word 1
   // invalidates hit the half picked by addr bit 6
   always_comb begin : wd_en_calc
      logic [1:0] quad;
      for (int q = 0; q < num_quads; q++) begin
         quad         = 2'(q);
         wd_en_new[q] = ((quad[0] ? inv_hit1 : inv_hit0) & (inv_addr[6] == quad[1])) |
                        (ld_inv & (ld_inv_index[6:5] == quad)) |
                        (is_ifill & (fill_index[6:5] == quad));
      end
   end

   // hold last enables while the queue is stalled
   assign wd_en = ifq_adv ? wd_en_new : wd_en_q;

   // ----------------------------------------------------------------------
   // valid-bit write enables
   // ----------------------------------------------------------------------

   // no invalidate-all while stalled
   assign inv_all_adv = inv_all & ifq_adv;

   // all four ways of the quadrant at {addr6, pa5}
   always_comb begin : wren_calc
      logic [1:0] quad;
      for (int q = 0; q < num_quads; q++) begin
         quad                         = 2'(q);
         icv_wren[q*num_ways +: num_ways] =
            ((quad[0] ? w1_dec_way : w0_dec_way) & {num_ways{wd_en[q]}}) |
            {num_ways{inv_all_adv & (inv_pa5 == quad[0]) & (inv_addr[6] == quad[1])}};
      end
   end

   // ----------------------------------------------------------------------
   // invalidate request
   // ----------------------------------------------------------------------

   assign invalidate_new = (is_inv_pkt & (word0_inv | word1_inv)) | inv_all | ld_inv;

   assign invreq      = ifq_adv ? invalidate_new : inv_q;
   // pending follows the packet even during a stall
   assign inv_pending = invalidate_new;

   // ----------------------------------------------------------------------
   // held state
   // ----------------------------------------------------------------------

   always_ff @(posedge rclk) begin
      if (reset) begin
         w0_way_q <= '0;
         w1_way_q <= '0;
         wd_en_q  <= '0;
         inv_q    <= 1'b0;
      end else if (ifq_adv) begin
         w0_way_q <= w0_way;
         w1_way_q <= w1_way;
         wd_en_q  <= wd_en_new;
         inv_q    <= invalidate_new;
      end
   end

   // ----------------------------------------------------------------------
   // write index
   // ----------------------------------------------------------------------

   // fill index for fills and stalls
   // invalidates cover both 32B halves so bit 5 is zero
   always_comb begin
      if (is_ifill | ~ifq_adv) begin
         icv_wrindex = fill_index;
      end else if (is_ld) begin
         icv_wrindex = ld_inv_index;
      end else begin
         icv_wrindex = {inv_addr, 1'b0};
      end
   end

endmodule

/* icache_invctl.sv */
`timescale 1ns/10ps

module icache_invctl import invctl_pkg::*; #(
   parameter int unsigned core_id = 0
) (
   input  logic                           rclk,
   input  logic                           reset,
   input  logic [cpx_width-1:0]           cpx_pkt,
   input  logic [way_w-1:0]               wrway,
   input  logic                           ifq_adv,
   input  logic [ic_idx_hi:5]             fill_index,
   input  logic                           ld_pcx_vld,
   input  logic [1:0]                     ld_pcx_tid,
   input  logic [ic_idx_hi:5]             ld_icache_index,
   output logic [num_quads*num_ways-1:0]  icv_wren,
   output logic [ic_idx_hi:5]             icv_wrindex,
   output logic [num_ways-1:0]            ict_dec_wrway,
   output logic                           invreq,
   output logic                           inv_pending
);

   // decoded packet
   logic               is_ld;
   logic               is_ifill;
   logic               is_inv_pkt;
   logic               ld_inv;
   logic               inv_all;
   logic [way_w-1:0]   ld_way;
   logic [1:0]         pkt_thr;
   logic               inv_pa5;
   logic [ic_idx_hi:6] inv_addr;
   // this core's invalidate words
   logic               word0_inv;
   logic               word1_inv;
   logic [way_w-1:0]   word0_way;
   logic [way_w-1:0]   word1_way;
   // index of the load that caused the invalidate
   logic [ic_idx_hi:5] ld_inv_index;

   cpx_inv_decode #(
      .core_id (core_id)
   ) u_cpx_inv_decode (
      .cpx_pkt    (cpx_pkt),
      .is_ld      (is_ld),
      .is_ifill   (is_ifill),
      .is_inv_pkt (is_inv_pkt),
      .ld_inv     (ld_inv),
      .inv_all    (inv_all),
      .ld_way     (ld_way),
      .pkt_thr    (pkt_thr),
      .inv_pa5    (inv_pa5),
      .inv_addr   (inv_addr),
      .word0_inv  (word0_inv),
      .word1_inv  (word1_inv),
      .word0_way  (word0_way),
      .word1_way  (word1_way)
   );

   ld_index_table u_ld_index_table (
      .rclk            (rclk),
      .reset           (reset),
      .ld_pcx_vld      (ld_pcx_vld),
      .ld_pcx_tid      (ld_pcx_tid),
      .ld_icache_index (ld_icache_index),
      .pkt_thr         (pkt_thr),
      .ld_inv_index    (ld_inv_index)
   );

   icv_write_ctl u_icv_write_ctl (
      .rclk          (rclk),
      .reset         (reset),
      .ifq_adv       (ifq_adv),
      .wrway         (wrway),
      .fill_index    (fill_index),
      .is_ld         (is_ld),
      .is_ifill      (is_ifill),
      .is_inv_pkt    (is_inv_pkt),
      .ld_inv        (ld_inv),
      .inv_all       (inv_all),
      .ld_way        (ld_way),
      .inv_pa5       (inv_pa5),
      .inv_addr      (inv_addr),
      .word0_inv     (word0_inv),
      .word1_inv     (word1_inv),
      .word0_way     (word0_way),
      .word1_way     (word1_way),
      .ld_inv_index  (ld_inv_index),
      .icv_wren      (icv_wren),
      .icv_wrindex   (icv_wrindex),
      .ict_dec_wrway (ict_dec_wrway),
      .invreq        (invreq),
      .inv_pending   (inv_pending)
   );

endmodule

/* tb_clock_gen.sv */
`timescale 1ns/10ps

module tb_clock_gen #(
   parameter int period       = 40,
   parameter int reset_cycles = 4
) (
   output logic rclk,
   output logic reset
);

   // free running clock that starts low
   initial begin
      rclk = 1'b0;
      forever #(period / 2) rclk = ~rclk;
   end

   // reset held over the first rising edges
   // released on a falling edge away from the sampling edge
   initial begin
      reset = 1'b1;
      repeat (reset_cycles) @(posedge rclk);
      @(negedge rclk);
      reset <= 1'b0;
   end

endmodule

/* tb_icache_invctl.sv */
`timescale 1ns/10ps

module tb_icache_invctl import invctl_pkg::*; ();

   // ----------------------------------------------------------------------
   // bench constants
   // ----------------------------------------------------------------------

   localparam int    clk_period = 40;
   localparam int    tb_core_id = 3;
   // seven stimulus and five expected tokens per vector line
   localparam int    fields     = 12;
   localparam int    max_vecs   = 64;
   localparam string pat_file   = "invctl_patterns.txt";
   // a lone ff in the first column closes the vector list
   localparam logic [cpx_width-1:0] end_mark = 'hff;

   // DUT ports
   logic                          rclk;
   logic                          reset;
   logic [cpx_width-1:0]          cpx_pkt;
   logic [way_w-1:0]              wrway;
   logic                          ifq_adv;
   logic [ic_idx_hi:5]            fill_index;
   logic                          ld_pcx_vld;
   logic [1:0]                    ld_pcx_tid;
   logic [ic_idx_hi:5]            ld_icache_index;
   logic [num_quads*num_ways-1:0] icv_wren;
   logic [ic_idx_hi:5]            icv_wrindex;
   logic [num_ways-1:0]           ict_dec_wrway;
   logic                          invreq;
   logic                          inv_pending;

   // raw tokens of the pattern file
   logic [cpx_width-1:0] pat_mem [max_vecs*fields];

   int   num_vecs;
   int   cur_vec;
   int   err_count;
   int   check_count;
   logic pat_loaded;

   tb_clock_gen #(
      .period       (clk_period),
      .reset_cycles (4)
   ) u_clock_gen (
      .rclk  (rclk),
      .reset (reset)
   );

   icache_invctl #(
      .core_id (tb_core_id)
   ) u_icache_invctl (
      .rclk            (rclk),
      .reset           (reset),
      .cpx_pkt         (cpx_pkt),
      .wrway           (wrway),
      .ifq_adv         (ifq_adv),
      .fill_index      (fill_index),
      .ld_pcx_vld      (ld_pcx_vld),
      .ld_pcx_tid      (ld_pcx_tid),
      .ld_icache_index (ld_icache_index),
      .icv_wren        (icv_wren),
      .icv_wrindex     (icv_wrindex),
      .ict_dec_wrway   (ict_dec_wrway),
      .invreq          (invreq),
      .inv_pending     (inv_pending)
   );

   // ----------------------------------------------------------------------
   // helpers
   // ----------------------------------------------------------------------

   // compare one output against its expected value
   task automatic check_value(
      input string       name,
      input logic [31:0] actual,
      input logic [31:0] expected
   );
      check_count++;
      if (actual !== expected) begin
         err_count++;
         $display("[ERROR] %0d ns vector %0d %s: got 0x%0h expected 0x%0h",
                  $time, cur_vec, name, actual, expected);
      end
   endtask

   // number of vectors before the end mark or -1 without one
   function automatic int count_vectors();
      for (int v = 0; v < max_vecs; v++) begin
         if (pat_mem[v * fields] == end_mark) begin
            return v;
         end
      end
      return -1;
   endfunction

   // put one vector on the DUT inputs
   task automatic apply_vector(input int v);
      int base;
      base            = v * fields;
      ifq_adv         = pat_mem[base][0];
      wrway           = pat_mem[base + 1][way_w-1:0];
      fill_index      = pat_mem[base + 2][ic_idx_sz-1:0];
      ld_pcx_vld      = pat_mem[base + 3][0];
      ld_pcx_tid      = pat_mem[base + 4][1:0];
      ld_icache_index = pat_mem[base + 5][ic_idx_sz-1:0];
      cpx_pkt         = pat_mem[base + 6];
   endtask

   // all five outputs against the expected columns
   task automatic check_vector(input int v);
      int base;
      base = v * fields;
      check_value("icv_wren", 32'(icv_wren),
                  32'(pat_mem[base + 7][num_quads*num_ways-1:0]));
      check_value("icv_wrindex", 32'(icv_wrindex),
                  32'(pat_mem[base + 8][ic_idx_sz-1:0]));
      check_value("ict_dec_wrway", 32'(ict_dec_wrway),
                  32'(pat_mem[base + 9][num_ways-1:0]));
      check_value("invreq", 32'(invreq), 32'(pat_mem[base + 10][0]));
      check_value("inv_pending", 32'(inv_pending), 32'(pat_mem[base + 11][0]));
   endtask

   // ----------------------------------------------------------------------
   // stimulus and checking
   // ----------------------------------------------------------------------

   initial begin : stimulus
      int found;
      // quiet inputs through reset
      ifq_adv         = 1'b0;
      wrway           = '0;
      fill_index      = '0;
      ld_pcx_vld      = 1'b0;
      ld_pcx_tid      = '0;
      ld_icache_index = '0;
      cpx_pkt         = '0;
      err_count       = 0;
      check_count     = 0;
      cur_vec         = 0;
      num_vecs        = 0;
      pat_loaded      = 1'b0;

      $readmemh(pat_file, pat_mem);
      found = count_vectors();
      if (found <= 0) begin
         err_count++;
         $display("pattern file %s holds no vectors or lacks the end mark", pat_file);
      end else begin
         num_vecs = found;
      end
      pat_loaded = 1'b1;

      @(negedge reset);
      for (int v = 0; v < num_vecs; v++) begin
         // new vector on the falling edge
         @(negedge rclk);
         cur_vec = v;
         apply_vector(v);
         // outputs settled 5 ns before the next rising edge
         #(clk_period / 2 - 5);
         check_vector(v);
      end

      $display("vectors %0d, checks %0d, errors %0d", num_vecs, check_count, err_count);
      if (err_count == 0) begin
         $display("Simulation passed");
      end else begin
         $display("Simulation failed");
      end
      $finish;
   end

   // ----------------------------------------------------------------------
   // watchdog
   // ----------------------------------------------------------------------

   // one clock per vector plus 20 cycles for reset and margin
   initial begin : watchdog
      int timeout_ns;
      wait (pat_loaded);
      timeout_ns = (num_vecs + 20) * clk_period;
      #(timeout_ns);
      $display("watchdog expired after %0d ns with vectors still unchecked", timeout_ns);
      $display("Simulation failed");
      $finish;
   end

endmodule

/* invctl_patterns.txt */
// adv wrway fill_idx ld_vld ld_tid ld_idx packet | exp: wren wrindex dec_wrway invreq pending
// all hex, one vector per line, core 3; a lone ff ends the list
// reset state and fills
0 0 2a 0 0 00 00000000000000000000000000000000 0000 2a 1 0 0
1 1 15 0 0 00 00000000000000000000000000000000 0000 00 2 0 0
1 2 2a 0 0 00 88000000000000000000000000000000 0400 2a 4 0 0
1 3 13 0 0 00 88000000000000000000000000000000 8000 13 8 0 0
1 0 40 0 0 00 88000000000000000000000000000000 0001 40 1 0 0
1 1 7d 0 0 00 88000000000000000000000000000000 0020 7d 2 0 0
0 3 3c 0 0 00 00000000000000000000000000000000 0020 3c 8 0 0
1 1 2a 0 0 00 08000000000000000000000000000000 0000 00 2 0 0
// store ack on both words, then stalls
1 0 11 0 0 00 a00b4000000000e00000000000006000 8200 5a 1 1 1
0 2 33 0 0 00 00000000000000000000000000000000 8200 33 4 1 0
0 1 0c 0 0 00 88000000000000000000000000000000 8200 0c 2 1 0
0 0 21 0 0 00 a00b4000000000e00000000000006000 8200 21 1 1 1
1 0 00 0 0 00 00000000000000000000000000000000 0000 00 1 0 0
0 0 5e 0 0 00 00000000000000000000000000000000 0000 5e 1 0 0
// stream acks
1 3 44 0 0 00 b0008000000000a00000000000000e00 0040 04 8 1 1
0 3 19 0 0 00 00000000000000000000000000000000 0040 19 8 1 0
1 0 00 0 0 00 b0300000000000000000000000000000 0000 00 1 0 0
// load strobes and load returns
1 0 00 1 1 26 00000000000000000000000000000000 0000 00 1 0 0
1 0 00 1 2 5b 00000000000000000000000000000000 0000 00 1 0 0
1 0 01 0 0 00 85800000000000000000000000000000 2000 5b 1 1 1
0 0 62 0 0 00 00000000000000000000000000000000 2000 62 1 1 0
1 2 00 0 0 00 87400000000000000000000000000000 0800 26 4 1 1
1 0 00 0 0 00 81800000000000000000000000000000 0000 5b 1 0 0
1 0 00 1 0 7f 86000000000000000000000000000000 0004 00 1 1 1
1 0 00 0 0 00 86000000000000000000000000000000 4000 7f 1 1 1
// evicts with invalidate all
1 2 70 0 0 00 983d0000000000000000000000000000 00f0 68 4 1 1
0 2 70 0 0 00 00000000000000000000000000000000 0000 70 4 1 0
1 1 0f 0 0 00 98204000000000200000000000006000 1f00 02 2 1 1
0 1 0f 0 0 00 983d0000000000000000000000000000 1200 0f 2 1 1
1 0 00 0 0 00 00000000000000000000000000000000 0000 00 1 0 0
// store ack for other cores only
1 0 00 0 0 00 a00000000000000e00000000e0000e00 0000 00 1 0 0
// end of vectors
ff

/* filelist.f */
invctl_pkg.sv
cpx_inv_decode.sv
ld_index_table.sv
icv_write_ctl.sv
icache_invctl.sv
tb_clock_gen.sv
tb_icache_invctl.sv

/* Makefile */
VERILATOR = verilator
VFLAGS    = --binary --timing -j 0
TOP       = tb_icache_invctl
FILELIST  = filelist.f
OBJ_DIR   = obj_dir
PASS_MSG  = Simulation passed

SIM_BIN   = $(OBJ_DIR)/V$(TOP)
SOURCES   = $(shell cat $(FILELIST))

.PHONY: all run clean

all: run

# rebuilt only when a source or the file list changes
$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	@out="$$(./$(SIM_BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
